// File: compile.f
+incdir+logic
logic/ioBusPkg.sv
logic/perifPkg.sv
logic/ioAddrDecoder.sv
logic/timerCfg.sv
logic/timerCounter.sv
logic/gpioPort.sv
logic/perifBlock.sv
testbench/perifBlock_props.sv
testbench/perifChecker.sv
testbench/perifBlockTb.sv

// File: logic/gpioPort.sv
`timescale 1ns/1ns
`default_nettype none

`include "perif_consts.svh"

module gpioPort (
  input  logic             clkH,
  input  logic             arstN,
  input  ioBusPkg::ioDataT ioMosi,
  input  logic             gpioWr,
  input  perifPkg::gpioT   gpioI,
  output perifPkg::gpioT   gpioO,
  output perifPkg::gpioT   gpioE,
  output perifPkg::gpioT   gpioInReg
);

  // low nibble drives the pins, next nibble enables them
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      gpioO <= '0;
      gpioE <= '0;
    end else if (gpioWr) begin
      gpioO <= ioMosi[`GPIO_CNT-1:0];
      gpioE <= ioMosi[2*`GPIO_CNT-1:`GPIO_CNT];
    end
  end

  // pin sample, one clock behind the pads
  always_ff @(posedge clkH) begin
    gpioInReg <= gpioI;
  end

endmodule

`default_nettype wire

// File: logic/ioAddrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "perif_consts.svh"

module ioAddrDecoder #(
  parameter ioBusPkg::ioAddrT baseAddr = `PERIF_BASE_ADDR,
  parameter ioBusPkg::accessT addrUsed = `PERIF_ADDR_USED
) (
  input  ioBusPkg::ioAddrT ioAddr,
  input  ioBusPkg::ioSizeT ioWrSize,
  input  ioBusPkg::ioSizeT ioRdSize,
  output logic             timerReloadWr,
  output logic             syncWr,
  output logic             gpioWr,
  output logic             timerRd,
  output logic             syncRd,
  output logic             gpioRd,
  output logic             addrAck,
  output logic             addrErr
);

  logic             addrHit;
  ioBusPkg::ioSizeT wrSize;
  ioBusPkg::ioSizeT rdSize;
  logic [3:0]       laneDec;
  ioBusPkg::accessT access;

  // upper fourteen bits pick the block
  assign addrHit = (ioAddr[15:2] == baseAddr[15:2]);
  assign wrSize  = addrHit ? ioWrSize : '0;
  assign rdSize  = addrHit ? ioRdSize : '0;

  // one-hot byte lane
  assign laneDec = 4'b0001 << ioAddr[1:0];

  // four bits per lane: byte rd, byte wr, word rd, word wr
  for (genvar lane = 0; lane < 4; lane++) begin : gLane
    assign access[lane*4+0] = laneDec[lane] & rdSize[0];
    assign access[lane*4+1] = laneDec[lane] & wrSize[0];
    assign access[lane*4+2] = laneDec[lane] & rdSize[1];
    assign access[lane*4+3] = laneDec[lane] & wrSize[1];
  end

  assign addrAck = |(access & addrUsed);

  // in the block, some size set, nothing mapped there
  assign addrErr = (|{ioWrSize, ioRdSize}) & addrHit & ~addrAck;

  // register strobes
  assign timerReloadWr = access[`OFS_TIMER*4+3];
  assign timerRd       = access[`OFS_TIMER*4+2];
  assign syncWr        = access[`OFS_SYNC*4+1];
  assign syncRd        = access[`OFS_SYNC*4+0];
  assign gpioWr        = access[`OFS_GPIO*4+1];
  assign gpioRd        = access[`OFS_GPIO*4+0];

endmodule

`default_nettype wire

// File: logic/ioBusPkg.sv
`default_nettype none

`include "perif_consts.svh"

package ioBusPkg;

  // full bus address
  typedef logic [15:0] ioAddrT;

  // one-hot access size, bit 1 word and bit 0 byte
  typedef logic [1:0] ioSizeT;

  // write and read data
  typedef logic [`IO_DATA_LEN-1:0] ioDataT;

  // one bit per lane, size and direction
  typedef logic [15:0] accessT;

endpackage

`default_nettype wire

// File: logic/perifBlock.sv
`timescale 1ns/1ns
`default_nettype none

`include "perif_consts.svh"

module perifBlock (
  input  logic             clkH,
  input  logic             arstN,
  input  ioBusPkg::ioAddrT ioAddr,
  input  ioBusPkg::ioSizeT ioWrSize,
  input  ioBusPkg::ioSizeT ioRdSize,
  input  ioBusPkg::ioDataT ioMosi,
  output ioBusPkg::ioDataT ioMiso,
  output logic             addrAck,
  output logic             addrErr,
  input  logic             sync1K,
  input  logic             sync1M,
  input  logic             countEn,
  input  logic             timerReset,
  input  perifPkg::gpioT   gpioI,
  output perifPkg::gpioT   gpioO,
  output perifPkg::gpioT   gpioE,
  output logic             timerNZ
);

  logic              timerReloadWr;
  logic              syncWr;
  logic              gpioWr;
  logic              timerRd;
  logic              syncRd;
  logic              gpioRd;
  perifPkg::timerT   reload;
  perifPkg::syncSelT syncSel;
  perifPkg::timerT   timerValue;
  perifPkg::gpioT    gpioInReg;

  ioAddrDecoder #(
    .baseAddr(`PERIF_BASE_ADDR),
    .addrUsed(`PERIF_ADDR_USED)
  ) uDecoder (
    .ioAddr       (ioAddr),
    .ioWrSize     (ioWrSize),
    .ioRdSize     (ioRdSize),
    .timerReloadWr(timerReloadWr),
    .syncWr       (syncWr),
    .gpioWr       (gpioWr),
    .timerRd      (timerRd),
    .syncRd       (syncRd),
    .gpioRd       (gpioRd),
    .addrAck      (addrAck),
    .addrErr      (addrErr)
  );

  timerCfg uTimerCfg (
    .clkH         (clkH),
    .arstN        (arstN),
    .ioMosi       (ioMosi),
    .timerReloadWr(timerReloadWr),
    .syncWr       (syncWr),
    .reload       (reload),
    .syncSel      (syncSel)
  );

  timerCounter uTimerCounter (
    .clkH         (clkH),
    .arstN        (arstN),
    .ioMosi       (ioMosi),
    .timerReloadWr(timerReloadWr),
    .reload       (reload),
    .syncSel      (syncSel),
    .sync1K       (sync1K),
    .sync1M       (sync1M),
    .countEn      (countEn),
    .timerReset   (timerReset),
    .timerValue   (timerValue),
    .timerNZ      (timerNZ)
  );

  gpioPort uGpio (
    .clkH     (clkH),
    .arstN    (arstN),
    .ioMosi   (ioMosi),
    .gpioWr   (gpioWr),
    .gpioI    (gpioI),
    .gpioO    (gpioO),
    .gpioE    (gpioE),
    .gpioInReg(gpioInReg)
  );

  // read strobes are one-hot, so the sources are simply or-ed
  // byte reads land in the low byte
  assign ioMiso =
    ({`IO_DATA_LEN{timerRd}} & ioBusPkg::ioDataT'(timerValue)) |
    ({`IO_DATA_LEN{syncRd}}  & ioBusPkg::ioDataT'(timerNZ)) |
    ({`IO_DATA_LEN{gpioRd}}  & ioBusPkg::ioDataT'(gpioInReg));

endmodule

`default_nettype wire

// File: logic/perifPkg.sv
`default_nettype none

`include "perif_consts.svh"

package perifPkg;

  // counter and reload value
  typedef logic [`TIMER_LEN-1:0] timerT;

  // one bit per pin
  typedef logic [`GPIO_CNT-1:0] gpioT;

  // tick source for the down counter
  typedef enum logic [1:0] {
    syncOff = 2'd0,
    sync1K  = 2'd1,
    sync1M  = 2'd2,
    syncClk = 2'd3
  } syncSelT;

endpackage

`default_nettype wire

// File: logic/perif_consts.svh
`ifndef PERIF_CONSTS_SVH
`define PERIF_CONSTS_SVH

// block base, the low two address bits select the lane
`define PERIF_BASE_ADDR 16'h0040

// access vector bit = offset * 4 + 2 * word + write
// timer word wr/rd (3,2), sync byte wr/rd (9,8), gpio byte wr/rd (13,12)
`define PERIF_ADDR_USED 16'h330C

// bus and peripheral widths
`define IO_DATA_LEN 16
`define TIMER_LEN 16
`define GPIO_CNT 4

// byte offsets inside the block
`define OFS_TIMER 0
`define OFS_SYNC 2
`define OFS_GPIO 3

`endif

// File: logic/timerCfg.sv
`timescale 1ns/1ns
`default_nettype none

module timerCfg (
  input  logic              clkH,
  input  logic              arstN,
  input  ioBusPkg::ioDataT  ioMosi,
  input  logic              timerReloadWr,
  input  logic              syncWr,
  output perifPkg::timerT   reload,
  output perifPkg::syncSelT syncSel
);

  // reload word, also loaded into the counter by the same write
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      reload <= '0;
    end else if (timerReloadWr) begin
      reload <= ioMosi;
    end
  end

  // tick select from the low two bits of the byte write
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      syncSel <= perifPkg::syncOff;
    end else if (syncWr) begin
      syncSel <= perifPkg::syncSelT'(ioMosi[1:0]);
    end
  end

endmodule

`default_nettype wire

// File: logic/timerCounter.sv
`timescale 1ns/1ns
`default_nettype none

module timerCounter (
  input  logic              clkH,
  input  logic              arstN,
  input  ioBusPkg::ioDataT  ioMosi,
  input  logic              timerReloadWr,
  input  perifPkg::timerT   reload,
  input  perifPkg::syncSelT syncSel,
  input  logic              sync1K,
  input  logic              sync1M,
  input  logic              countEn,
  input  logic              timerReset,
  output perifPkg::timerT   timerValue,
  output logic              timerNZ
);

  perifPkg::timerT count;
  logic            tick;
  logic            countNZ;

  // tick source mux
  always_comb begin
    case (syncSel)
      perifPkg::syncOff: tick = 1'b0;
      perifPkg::sync1K:  tick = sync1K;
      perifPkg::sync1M:  tick = sync1M;
      default:           tick = 1'b1;
    endcase
  end

  assign countNZ = |count;

  // bus load beats restart, restart beats decrement
  always_ff @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      count   <= '0;
      timerNZ <= 1'b0;
    end else begin
      if (timerReloadWr) begin
        count <= ioMosi;
      end else if (timerReset) begin
        count <= reload;
      end else if (countNZ && countEn && tick) begin
        count <= count - perifPkg::timerT'(1);
      end
      // lags the counter by one clock
      timerNZ <= countNZ;
    end
  end

  assign timerValue = count;

endmodule

`default_nettype wire

// File: testbench/perifBlockTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "perif_consts.svh"

module perifBlockTb;

  localparam ioBusPkg::ioAddrT baseAddr = `PERIF_BASE_ADDR;
  localparam int unsigned seed = 32'h2dfc9d75;
  localparam int nzTimeout = 100;

  logic clkH, arstN, checkOn;
  ioBusPkg::ioAddrT ioAddr;
  ioBusPkg::ioSizeT ioWrSize, ioRdSize;
  ioBusPkg::ioDataT ioMosi, ioMiso, expMiso;
  logic addrAck, addrErr, timerNZ;
  logic sync1K, sync1M, countEn, timerReset;
  perifPkg::gpioT gpioI, gpioO, gpioE;
  int timeouts;

  // reference model state
  perifPkg::timerT mCount, mReload;
  perifPkg::syncSelT mSel;
  perifPkg::gpioT mGpioO, mGpioE, mGpioIn;
  logic mNz;
  logic [7:0] strobe;

  perifBlock uut (.*);

  perifChecker chk (
    .clkH(clkH), .checkOn(checkOn),
    .ioMiso(ioMiso), .expMiso(expMiso),
    .addrAck(addrAck), .expAck(strobe[7]),
    .addrErr(addrErr), .expErr(strobe[6]),
    .gpioO(gpioO), .expGpioO(mGpioO),
    .gpioE(gpioE), .expGpioE(mGpioE),
    .timerNZ(timerNZ), .expNZ(mNz)
  );

  always #50 clkH = ~clkH;

  // {ack, err, timerWr, syncWr, gpioWr, timerRd, syncRd, gpioRd}
  function automatic logic [7:0] decodeAccess(input ioBusPkg::ioAddrT addr,
                                              input ioBusPkg::ioSizeT wr,
                                              input ioBusPkg::ioSizeT rd);
    logic [7:0] s;
    s = '0;
    if (addr[15:2] == baseAddr[15:2]) begin
      s[5] = (addr[1:0] == `OFS_TIMER) && wr[1];
      s[4] = (addr[1:0] == `OFS_SYNC) && wr[0];
      s[3] = (addr[1:0] == `OFS_GPIO) && wr[0];
      s[2] = (addr[1:0] == `OFS_TIMER) && rd[1];
      s[1] = (addr[1:0] == `OFS_SYNC) && rd[0];
      s[0] = (addr[1:0] == `OFS_GPIO) && rd[0];
      s[7] = |s[5:0];
      s[6] = (|{wr, rd}) && !s[7];
    end
    return s;
  endfunction

  function automatic logic tickActive(input perifPkg::syncSelT sel, input logic k, input logic m);
    case (sel)
      perifPkg::sync1K:  return k;
      perifPkg::sync1M:  return m;
      perifPkg::syncClk: return 1'b1;
      default:           return 1'b0;
    endcase
  endfunction

  // load, then restart, then decrement
  function automatic perifPkg::timerT nextCount(input perifPkg::timerT count, input logic loadWr,
      input ioBusPkg::ioDataT mosi, input logic restart, input perifPkg::timerT reload,
      input logic en, input logic tick);
    if (loadWr) return mosi;
    if (restart) return reload;
    if (count != '0 && en && tick) return count - 16'd1;
    return count;
  endfunction

  assign strobe = decodeAccess(ioAddr, ioWrSize, ioRdSize);
  assign expMiso = strobe[2] ? ioBusPkg::ioDataT'(mCount) :
                   strobe[1] ? ioBusPkg::ioDataT'(mNz) :
                   strobe[0] ? ioBusPkg::ioDataT'(mGpioIn) : '0;

  always @(posedge clkH or negedge arstN) begin
    if (!arstN) begin
      mCount <= '0;
      mNz <= 1'b0;
      mReload <= '0;
      mSel <= perifPkg::syncOff;
      mGpioO <= '0;
      mGpioE <= '0;
    end else begin
      mCount <= nextCount(mCount, strobe[5], ioMosi, timerReset, mReload, countEn,
                          tickActive(mSel, sync1K, sync1M));
      mNz <= (mCount != '0);
      if (strobe[5]) mReload <= ioMosi;
      if (strobe[4]) mSel <= perifPkg::syncSelT'(ioMosi[1:0]);
      if (strobe[3]) begin
        mGpioO <= ioMosi[3:0];
        mGpioE <= ioMosi[7:4];
      end
    end
  end

  always @(posedge clkH) mGpioIn <= gpioI;

  task automatic step();
    @(posedge clkH);
    #5;
  endtask

  task automatic driveBus(input logic [15:0] addr, input logic [1:0] wr, input logic [1:0] rd,
                          input logic [15:0] mosi);
    ioAddr = addr;
    ioWrSize = wr;
    ioRdSize = rd;
    ioMosi = mosi;
  endtask

  task automatic waitTimerIdle();
    int n;
    for (n = 0; n < nzTimeout && timerNZ; n++) begin
      step();
    end
    if (timerNZ) begin
      $display("Timeout: timerNZ still high after %0d cycles", nzTimeout);
      timeouts++;
    end
  endtask

  initial begin
    int unsigned r;
    clkH = 0;
    arstN = 0;
    checkOn = 0;
    timeouts = 0;
    driveBus(16'h0, 2'b00, 2'b00, 16'h0);
    {sync1K, sync1M, countEn, timerReset} = '0;
    gpioI = '0;
    r = $urandom(seed);
    repeat (3) @(posedge clkH);
    #5;
    arstN = 1;
    checkOn = 1;

    // decode inside the block, next to it and anywhere
    repeat (200) begin
      r = $urandom();
      driveBus(r[0] ? baseAddr + 16'(r[3:2]) :
               r[1] ? baseAddr + 16'd4 + 16'(r[3:2]) : 16'($urandom()),
               (r[5:4] == 2'b11) ? 2'b00 : r[5:4], (r[7:6] == 2'b11) ? 2'b00 : r[7:6],
               16'($urandom()));
      step();
    end
    chk.endTest("decode");

    driveBus(baseAddr + `OFS_GPIO, 2'b01, 2'b00, 16'h00A5);
    step();
    for (int i = 0; i < 8; i++) begin
      gpioI = perifPkg::gpioT'($urandom());
      driveBus(baseAddr + `OFS_GPIO, i[0] ? 2'b01 : 2'b00, 2'b01, 16'($urandom()));
      step();
    end
    chk.endTest("gpio");

    driveBus(baseAddr + `OFS_SYNC, 2'b01, 2'b00, 16'(perifPkg::syncClk));
    step();
    countEn = 1;
    driveBus(baseAddr + `OFS_TIMER, 2'b10, 2'b00, 16'd12);
    step();
    driveBus(baseAddr + `OFS_TIMER, 2'b00, 2'b10, 16'h0);
    // flag lags the load by one clock
    step();
    waitTimerIdle();
    repeat (3) step();
    chk.endTest("count at clk");

    driveBus(baseAddr + `OFS_SYNC, 2'b01, 2'b00, 16'(perifPkg::sync1K));
    step();
    driveBus(baseAddr + `OFS_TIMER, 2'b10, 2'b00, 16'd200);
    step();
    driveBus(baseAddr + `OFS_TIMER, 2'b00, 2'b10, 16'h0);
    repeat (100) begin
      r = $urandom();
      sync1K = r[0];
      sync1M = r[1];
      countEn = r[2] | r[3];
      step();
    end
    {sync1K, sync1M, countEn} = 3'b001;
    chk.endTest("tick gating");

    driveBus(baseAddr + `OFS_SYNC, 2'b01, 2'b00, 16'(perifPkg::syncClk));
    step();
    driveBus(baseAddr + `OFS_TIMER, 2'b10, 2'b00, 16'd50);
    step();
    driveBus(baseAddr + `OFS_TIMER, 2'b00, 2'b10, 16'h0);
    repeat (10) step();
    timerReset = 1;
    step();
    timerReset = 0;
    repeat (5) step();
    // bus load wins over restart
    timerReset = 1;
    driveBus(baseAddr + `OFS_TIMER, 2'b10, 2'b10, 16'd77);
    step();
    timerReset = 0;
    driveBus(baseAddr + `OFS_TIMER, 2'b00, 2'b10, 16'h0);
    repeat (3) step();
    timerReset = 1;
    step();
    timerReset = 0;
    repeat (3) step();
    chk.endTest("restart");

    checkOn = 0;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d, timeouts %0d",
             chk.testsRun, chk.testsFailed, chk.totalErrors, uut.uProps.failCount,
             timeouts);
    if (chk.totalErrors == 0 && uut.uProps.failCount == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/perifBlock_props.sv
`timescale 1ns/1ns
`default_nettype none

module perifBlock_props (
  input logic            clkH,
  input logic            arstN,
  input logic            addrAck,
  input logic            addrErr,
  input logic            gpioWr,
  input perifPkg::gpioT  gpioO,
  input perifPkg::gpioT  gpioE,
  input perifPkg::timerT timerValue,
  input logic            timerNZ
);

  // assertion failures so far
  int failCount = 0;

  // a mapped access is never an error as well
  ackErrExclusive: assert property (@(posedge clkH) disable iff (!arstN)
    !(addrAck && addrErr))
    else begin
      $error("addrAck and addrErr high together");
      failCount++;
    end

  // flag is the counter state of the previous clock
  nzFollowsCount: assert property (@(posedge clkH) disable iff (!arstN)
    timerNZ == $past(timerValue != '0))
    else begin
      $error("timerNZ does not follow the counter");
      failCount++;
    end

  gpioHolds: assert property (@(posedge clkH) disable iff (!arstN)
    !gpioWr |=> ($stable(gpioO) && $stable(gpioE)))
    else begin
      $error("gpio output or enable changed without a write");
      failCount++;
    end

endmodule

bind perifBlock perifBlock_props uProps (
  .clkH      (clkH),
  .arstN     (arstN),
  .addrAck   (addrAck),
  .addrErr   (addrErr),
  .gpioWr    (gpioWr),
  .gpioO     (gpioO),
  .gpioE     (gpioE),
  .timerValue(timerValue),
  .timerNZ   (timerNZ)
);

`default_nettype wire

// File: testbench/perifChecker.sv
`timescale 1ns/1ns
`default_nettype none

module perifChecker (
  input logic             clkH,
  input logic             checkOn,
  input ioBusPkg::ioDataT ioMiso,
  input ioBusPkg::ioDataT expMiso,
  input logic             addrAck,
  input logic             expAck,
  input logic             addrErr,
  input logic             expErr,
  input perifPkg::gpioT   gpioO,
  input perifPkg::gpioT   expGpioO,
  input perifPkg::gpioT   gpioE,
  input perifPkg::gpioT   expGpioE,
  input logic             timerNZ,
  input logic             expNZ
);

  int testChecks = 0;
  int testErrors = 0;
  int totalErrors = 0;
  int testsRun = 0;
  int testsFailed = 0;

  task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
    testChecks++;
    if (got !== exp) begin
      testErrors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // inputs change just after the rising edge, so all is settled here
  always @(negedge clkH) begin
    if (checkOn) begin
      compare("ioMiso", ioMiso, expMiso);
      compare("addrAck", addrAck, expAck);
      compare("addrErr", addrErr, expErr);
      compare("gpioO", gpioO, expGpioO);
      compare("gpioE", gpioE, expGpioE);
      compare("timerNZ", timerNZ, expNZ);
    end
  end

  task automatic endTest(input string name);
    testsRun++;
    if (testErrors != 0) begin
      testsFailed++;
    end
    $display("test %-14s %s, %0d checks, %0d errors", name,
             (testErrors == 0) ? "ok" : "FAILED", testChecks, testErrors);
    totalErrors += testErrors;
    testChecks = 0;
    testErrors = 0;
  endtask

endmodule

`default_nettype wire
